//--- logic/npu_pkg.sv
`default_nettype none

package npu_pkg;

	// image geometry
	localparam int IMG_DIM   = 8;
	localparam int PIX_COUNT = IMG_DIM * IMG_DIM;
	localparam int POOL_DIM  = IMG_DIM / 2;
	localparam int RES_COUNT = POOL_DIM * POOL_DIM;
	localparam int TAPS      = 9;

	// load address map, pixels sit below WEIGHT_BASE
	localparam int WEIGHT_BASE = PIX_COUNT;
	localparam int BIAS_ADDR   = WEIGHT_BASE + TAPS;

	localparam int OUT_SHIFT = 4; // applied before saturation

	typedef logic        [7:0]  pixel_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [19:0] sum_t;
	typedef logic signed [7:0]  res_t;

	// tap 0 is top-left, raster order
	typedef pixel_t  [TAPS-1:0] taps_t;
	typedef weight_t [TAPS-1:0] weights_t;

	typedef logic [6:0]  ld_addr_t;
	typedef logic [15:0] ld_data_t;
	typedef logic [2:0]  coord_t;

endpackage

`default_nettype wire

//--- logic/operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module operand_store (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_ld_req,
	input  npu_pkg::ld_addr_t   i_ld_addr,
	input  npu_pkg::ld_data_t   i_ld_data,
	output logic                o_ld_ack,
	input  wire                 i_issue,
	input  npu_pkg::coord_t     i_row,
	input  npu_pkg::coord_t     i_col,
	input  wire  [8:0]          i_tap_mask,
	output logic                o_taps_valid,
	output npu_pkg::taps_t      o_taps,
	output npu_pkg::weights_t   o_weights,
	output npu_pkg::bias_t      o_bias
);

	npu_pkg::pixel_t pix_mem [npu_pkg::PIX_COUNT];
	npu_pkg::taps_t  taps_nxt;
	logic [3:0]      wt_idx;

	assign wt_idx = 4'(i_ld_addr - npu_pkg::WEIGHT_BASE);

	// four-phase load: write on req, drop ack once req is gone
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ld_ack  <= 1'b0;
			o_weights <= '0;
			o_bias    <= '0;
			for (int i = 0; i < npu_pkg::PIX_COUNT; i++) begin
				pix_mem[i] <= '0;
			end
		end else if (i_ld_req && !o_ld_ack) begin
			o_ld_ack <= 1'b1;
			if (i_ld_addr < npu_pkg::ld_addr_t'(npu_pkg::WEIGHT_BASE)) begin
				pix_mem[i_ld_addr[5:0]] <= i_ld_data[7:0];
			end else if (i_ld_addr < npu_pkg::ld_addr_t'(npu_pkg::BIAS_ADDR)) begin
				o_weights[wt_idx] <= i_ld_data[7:0];
			end else if (i_ld_addr == npu_pkg::ld_addr_t'(npu_pkg::BIAS_ADDR)) begin
				o_bias <= i_ld_data;
			end // anything higher is acked and dropped
		end else if (!i_ld_req && o_ld_ack) begin
			o_ld_ack <= 1'b0;
		end
	end

	// neighbours of (row, col), coordinates wrap but the mask zeroes those taps
	always_comb begin
		npu_pkg::coord_t r;
		npu_pkg::coord_t c;
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			r = i_row + npu_pkg::coord_t'(k / 3) - 3'd1;
			c = i_col + npu_pkg::coord_t'(k % 3) - 3'd1;
			taps_nxt[k] = i_tap_mask[k] ? pix_mem[{r, c}] : '0;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) o_taps_valid <= 1'b0;
		else o_taps_valid <= i_issue;
	end

	always_ff @(posedge clk) begin
		if (i_issue) o_taps <= taps_nxt;
	end

	a_ld_addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_ld_req && $past(i_ld_req) |-> $stable(i_ld_addr));

endmodule

`default_nettype wire

//--- logic/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer (
	input  wire              clk,
	input  wire              i_arst_n,
	input  wire              i_start,
	input  wire              i_group_done,
	output logic             o_busy,
	output logic             o_issue,
	output npu_pkg::coord_t  o_row,
	output npu_pkg::coord_t  o_col,
	output logic [8:0]       o_tap_mask
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_t;

	localparam npu_pkg::coord_t EDGE_LAST = npu_pkg::coord_t'(npu_pkg::IMG_DIM - 1);

	state_t     state;
	logic [3:0] grp; // {group row, group col}
	logic [1:0] pos;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			grp   <= '0;
			pos   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_ISSUE;
						grp   <= '0;
						pos   <= '0;
					end
				end
				ST_ISSUE: begin
					pos <= pos + 2'd1;
					if (pos == 2'd3) state <= ST_WAIT;
				end
				ST_WAIT: begin
					// hold off until the pooled result has been taken
					if (i_group_done) begin
						grp   <= grp + 4'd1;
						state <= (grp == 4'(npu_pkg::RES_COUNT - 1)) ? ST_IDLE : ST_ISSUE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign o_busy  = (state != ST_IDLE);
	assign o_issue = (state == ST_ISSUE);

	// visit order (0,0) (0,1) (1,1) (1,0)
	assign o_row = {grp[3:2], pos[1]};
	assign o_col = {grp[1:0], pos[1] ^ pos[0]};

	always_comb begin
		o_tap_mask = '1;
		if (o_row == '0)       o_tap_mask[2:0] = '0; // top
		if (o_row == EDGE_LAST) o_tap_mask[8:6] = '0; // bottom
		if (o_col == '0) begin
			o_tap_mask[0] = 1'b0;
			o_tap_mask[3] = 1'b0;
			o_tap_mask[6] = 1'b0;
		end
		if (o_col == EDGE_LAST) begin
			o_tap_mask[2] = 1'b0;
			o_tap_mask[5] = 1'b0;
			o_tap_mask[8] = 1'b0;
		end
	end

	// a done pulse outside WAIT would be lost and stall the run
	a_done_only_in_wait: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_group_done |-> state == ST_WAIT);

endmodule

`default_nettype wire

//--- logic/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_taps_valid,
	input  npu_pkg::taps_t      i_taps,
	input  npu_pkg::weights_t   i_weights,
	input  npu_pkg::bias_t      i_bias,
	output logic                o_sum_valid,
	output npu_pkg::sum_t       o_sum
);

	npu_pkg::sum_t sum_nxt;

	// pixels are unsigned, so widen with a zero before the signed multiply
	always_comb begin
		logic signed [8:0]  pix_s;
		logic signed [16:0] prod;
		sum_nxt = npu_pkg::sum_t'(i_bias);
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			pix_s   = $signed({1'b0, i_taps[k]});
			prod    = pix_s * $signed(i_weights[k]);
			sum_nxt = sum_nxt + npu_pkg::sum_t'(prod);
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) o_sum_valid <= 1'b0;
		else o_sum_valid <= i_taps_valid;
	end

	always_ff @(posedge clk) begin
		if (i_taps_valid) o_sum <= sum_nxt;
	end

endmodule

`default_nettype wire

//--- logic/pool_relu.sv
`timescale 1ns/1ps
`default_nettype none

module pool_relu (
	input  wire              clk,
	input  wire              i_arst_n,
	input  wire              i_sum_valid,
	input  npu_pkg::sum_t    i_sum,
	input  wire              i_relu_en,
	input  wire              i_res_ack,
	output logic             o_res_req,
	output npu_pkg::res_t    o_res_data,
	output logic             o_group_done
);

	logic [1:0]    cnt;
	logic          pend; // result held back while ack is still high
	logic          last;
	npu_pkg::sum_t max_q;
	npu_pkg::sum_t max_nxt;
	npu_pkg::sum_t relu_v;
	npu_pkg::sum_t shr_v;
	npu_pkg::res_t res_nxt;

	assign last    = i_sum_valid && (cnt == 2'd3);
	assign max_nxt = (cnt == 2'd0 || i_sum > max_q) ? i_sum : max_q;
	assign relu_v  = (i_relu_en && max_nxt < 0) ? '0 : max_nxt;
	assign shr_v   = relu_v >>> npu_pkg::OUT_SHIFT;

	always_comb begin
		if (shr_v > npu_pkg::sum_t'(127)) res_nxt = 8'sd127;
		else if (shr_v < npu_pkg::sum_t'(-128)) res_nxt = -8'sd128;
		else res_nxt = shr_v[7:0];
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt          <= '0;
			pend         <= 1'b0;
			o_res_req    <= 1'b0;
			o_group_done <= 1'b0;
		end else begin
			o_group_done <= 1'b0;
			if (i_sum_valid) cnt <= cnt + 2'd1;
			if (o_res_req) begin
				if (i_res_ack) begin
					o_res_req    <= 1'b0;
					o_group_done <= 1'b1;
				end
			end else if ((last || pend) && !i_res_ack) begin
				o_res_req <= 1'b1;
				pend      <= 1'b0;
			end else if (last) begin
				pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_sum_valid) max_q <= max_nxt;
		if (last) o_res_data <= res_nxt;
	end

	a_no_sum_during_req: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_res_req |-> !i_sum_valid);

endmodule

`default_nettype wire

//--- logic/npu_top.sv
`timescale 1ns/1ps
`default_nettype none

module npu_top (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_ld_req,
	input  npu_pkg::ld_addr_t   i_ld_addr,
	input  npu_pkg::ld_data_t   i_ld_data,
	output logic                o_ld_ack,
	input  wire                 i_start,
	input  wire                 i_relu_en,
	output logic                o_busy,
	output logic                o_res_req,
	output npu_pkg::res_t       o_res_data,
	input  wire                 i_res_ack
);

	logic              issue;
	npu_pkg::coord_t   row;
	npu_pkg::coord_t   col;
	logic [8:0]        tap_mask;
	logic              taps_valid;
	npu_pkg::taps_t    taps;
	npu_pkg::weights_t weights;
	npu_pkg::bias_t    bias;
	logic              sum_valid;
	npu_pkg::sum_t     sum;
	logic              group_done;

	conv_sequencer u_seq (
		.clk, .i_arst_n, .i_start,
		.i_group_done (group_done),
		.o_busy,
		.o_issue      (issue),
		.o_row        (row),
		.o_col        (col),
		.o_tap_mask   (tap_mask)
	);

	operand_store u_store (
		.clk, .i_arst_n, .i_ld_req, .i_ld_addr, .i_ld_data, .o_ld_ack,
		.i_issue      (issue),
		.i_row        (row),
		.i_col        (col),
		.i_tap_mask   (tap_mask),
		.o_taps_valid (taps_valid),
		.o_taps       (taps),
		.o_weights    (weights),
		.o_bias       (bias)
	);

	conv_mac u_mac (
		.clk, .i_arst_n,
		.i_taps_valid (taps_valid),
		.i_taps       (taps),
		.i_weights    (weights),
		.i_bias       (bias),
		.o_sum_valid  (sum_valid),
		.o_sum        (sum)
	);

	pool_relu u_pool (
		.clk, .i_arst_n,
		.i_sum_valid  (sum_valid),
		.i_sum        (sum),
		.i_relu_en, .i_res_ack, .o_res_req, .o_res_data,
		.o_group_done (group_done)
	);

endmodule

`default_nettype wire

//--- tb/npu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npu_tb;

	localparam int RUNS            = 5;
	localparam int LOAD_CYCLES     = 200 * 4;
	localparam int WATCHDOG_CYCLES = RUNS * 16 * 40 + LOAD_CYCLES + 16;

	logic              clk;
	logic              i_arst_n;
	logic              i_ld_req;
	npu_pkg::ld_addr_t i_ld_addr;
	npu_pkg::ld_data_t i_ld_data;
	logic              o_ld_ack;
	logic              i_start;
	logic              i_relu_en;
	logic              o_busy;
	logic              o_res_req;
	npu_pkg::res_t     o_res_data;
	logic              i_res_ack;

	logic [31:0] lfsr_state;
	int          val_errs;
	int          other_errs;
	int          pix_mir [npu_pkg::PIX_COUNT]; // host-side copies of loaded operands
	int          w_mir [npu_pkg::TAPS];
	int          bias_mir;
	int          got_res [npu_pkg::RES_COUNT];

	npu_top u_npu_top (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_ld_req   (i_ld_req),
		.i_ld_addr  (i_ld_addr),
		.i_ld_data  (i_ld_data),
		.o_ld_ack   (o_ld_ack),
		.i_start    (i_start),
		.i_relu_en  (i_relu_en),
		.o_busy     (o_busy),
		.o_res_req  (o_res_req),
		.o_res_data (o_res_data),
		.i_res_ack  (i_res_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps at bits 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
			val_errs++;
		end
	endtask

	function automatic int pix_at(input int r, input int c);
		if (r < 0 || r >= npu_pkg::IMG_DIM || c < 0 || c >= npu_pkg::IMG_DIM) return 0;
		return pix_mir[r * npu_pkg::IMG_DIM + c];
	endfunction

	function automatic int conv_at(input int r, input int c);
		int acc;
		acc = bias_mir;
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			acc += pix_at(r + k / 3 - 1, c + k % 3 - 1) * w_mir[k];
		end
		return acc;
	endfunction

	// max over the 2x2 group, then relu, shift, saturate
	function automatic int pooled(input int gr, input int gc, input bit relu);
		int m;
		int s;
		m = conv_at(2 * gr, 2 * gc);
		for (int p = 1; p < 4; p++) begin
			s = conv_at(2 * gr + p / 2, 2 * gc + p % 2);
			if (s > m) m = s;
		end
		if (relu && m < 0) m = 0;
		m = m >>> npu_pkg::OUT_SHIFT;
		if (m > 127) m = 127;
		else if (m < -128) m = -128;
		return m;
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic load_word(input int addr, input int data);
		i_ld_req  = 1'b1;
		i_ld_addr = npu_pkg::ld_addr_t'(addr);
		i_ld_data = npu_pkg::ld_data_t'(data);
		@(posedge clk); #1;
		check_val("o_ld_ack", o_ld_ack, 1);
		i_ld_req = 1'b0;
		@(posedge clk); #1;
		check_val("o_ld_ack", o_ld_ack, 0);
	endtask

	task automatic load_rand_weights(input bit neg_centre);
		logic [31:0] b;
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			get_bits(8, b);
			if (neg_centre && k == 4) b[7] = 1'b1; // pulls sums negative
			w_mir[k] = int'($signed(b[7:0]));
			load_word(npu_pkg::WEIGHT_BASE + k, w_mir[k]);
		end
		if (neg_centre) begin
			get_bits(15, b);
			bias_mir = -int'(b[14:0]);
		end else begin
			get_bits(16, b);
			bias_mir = int'($signed(b[15:0]));
		end
		load_word(npu_pkg::BIAS_ADDR, bias_mir);
	endtask

	task automatic run_conv(input bit relu, input string tag);
		logic [31:0] b;
		int          cnt;
		i_relu_en = relu;
		i_start   = 1'b1;
		@(posedge clk); #1;
		i_start = 1'b0;
		check_val("o_busy", o_busy, 1);
		for (int i = 0; i < npu_pkg::RES_COUNT; i++) begin
			cnt = 0;
			while (!o_res_req && cnt < 32) begin
				@(posedge clk); #1;
				cnt++;
			end
			if (!o_res_req) begin
				$display("result %0d of the %s run never arrived", i, tag);
				other_errs++;
				return;
			end
			got_res[i] = int'(o_res_data);
			check_val("o_res_data", got_res[i], pooled(i / npu_pkg::POOL_DIM,
				i % npu_pkg::POOL_DIM, relu));
			get_bits(3, b); // ack delay 0 to 7
			repeat (b) begin
				@(posedge clk); #1;
			end
			i_res_ack = 1'b1;
			cnt = 0;
			while (o_res_req && cnt < 8) begin
				@(posedge clk); #1;
				cnt++;
			end
			if (o_res_req) begin
				$display("o_res_req stayed high after ack in the %s run", tag);
				other_errs++;
			end
			get_bits(4, b); // ack held 0 to 15 cycles after req falls
			repeat (b) begin
				@(posedge clk); #1;
			end
			i_res_ack = 1'b0;
		end
		cnt = 0;
		while (o_busy && cnt < 8) begin
			@(posedge clk); #1;
			cnt++;
		end
		check_val("o_busy", o_busy, 0);
		check_val("o_res_req", o_res_req, 0); // no seventeenth result
	endtask

	// req may only rise once ack was seen low
	initial begin
		logic prev_req;
		logic prev_ack;
		prev_req = 1'b0;
		prev_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (o_res_req && !prev_req && prev_ack) begin
				$display("o_res_req rose at %0t while i_res_ack was still high", $time);
				other_errs++;
			end
			prev_req = o_res_req;
			prev_ack = i_res_ack;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("value errors: %0d, other errors: %0d", val_errs, other_errs + 1);
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] b;
		int          neg_cnt;
		lfsr_state = 32'd80702;
		val_errs   = 0;
		other_errs = 0;
		i_arst_n   = 1'b0;
		i_ld_req   = 1'b0;
		i_ld_addr  = '0;
		i_ld_data  = '0;
		i_start    = 1'b0;
		i_relu_en  = 1'b0;
		i_res_ack  = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		i_arst_n = 1'b1;
		check_val("o_ld_ack", o_ld_ack, 0);
		check_val("o_busy", o_busy, 0);
		check_val("o_res_req", o_res_req, 0);
		@(posedge clk); #1;

		for (int a = 0; a < npu_pkg::PIX_COUNT; a++) begin
			get_bits(16, b);
			pix_mir[a] = int'(b[7:0]);
			load_word(a, b);
		end
		load_rand_weights(1'b1);
		get_bits(16, b);
		load_word(100, b); // unused, must change nothing

		run_conv(1'b0, "random");
		neg_cnt = 0;
		foreach (got_res[i]) if (got_res[i] < 0) neg_cnt++;
		if (neg_cnt == 0) begin
			$display("the random run gave no negative result");
			other_errs++;
		end

		run_conv(1'b1, "relu");
		foreach (got_res[i]) begin
			if (got_res[i] < 0) begin
				$display("relu run gave negative result %0d at index %0d", got_res[i], i);
				other_errs++;
			end
		end

		load_rand_weights(1'b0); // image stays
		run_conv(1'b0, "reload");

		for (int a = 0; a < npu_pkg::PIX_COUNT; a++) begin
			pix_mir[a] = 255;
			load_word(a, 255);
		end
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			w_mir[k] = 1;
			load_word(npu_pkg::WEIGHT_BASE + k, 1);
		end
		bias_mir = 0;
		load_word(npu_pkg::BIAS_ADDR, 0);
		run_conv(1'b0, "flat");
		foreach (got_res[i]) check_val("o_res_data", got_res[i], 127);

		// only tap 0, exposes top and left padding
		for (int k = 0; k < npu_pkg::TAPS; k++) begin
			w_mir[k] = (k == 0) ? 1 : 0;
			load_word(npu_pkg::WEIGHT_BASE + k, w_mir[k]);
		end
		run_conv(1'b0, "tap0");
		check_val("o_res_data", got_res[0], 15);

		$display("value errors: %0d, other errors: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/npu_pkg.sv
logic/operand_store.sv
logic/conv_sequencer.sv
logic/conv_mac.sv
logic/pool_relu.sv
logic/npu_top.sv
tb/npu_tb.sv

//--- Bender.yml
package:
  name: npu_conv

sources:
  - logic/npu_pkg.sv
  - logic/operand_store.sv
  - logic/conv_sequencer.sv
  - logic/conv_mac.sv
  - logic/pool_relu.sv
  - logic/npu_top.sv
  - target: test
    files:
      - tb/npu_tb.sv
